// ==== include/exe_ref_model.svh ====
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

function automatic rv_exe_pkg::word_t ref_alu(rv_exe_pkg::alu_op_t op,
                                              rv_exe_pkg::word_t a, rv_exe_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        rv_exe_pkg::alu_add:  return a + b;
        rv_exe_pkg::alu_sub:  return a - b;
        rv_exe_pkg::alu_sll:  return a << sh;
        rv_exe_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_exe_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        rv_exe_pkg::alu_xor:  return a ^ b;
        rv_exe_pkg::alu_srl:  return a >> sh;
        rv_exe_pkg::alu_sra:  return rv_exe_pkg::word_t'($signed(a) >>> sh);
        rv_exe_pkg::alu_or:   return a | b;
        default:              return a & b;
    endcase
endfunction

function automatic logic ref_cmp(rv_exe_pkg::cmp_op_t op,
                                 rv_exe_pkg::word_t a, rv_exe_pkg::word_t b);
    case (op)
        rv_exe_pkg::beq:  return a == b;
        rv_exe_pkg::bne:  return a != b;
        rv_exe_pkg::blt:  return $signed(a) < $signed(b);
        rv_exe_pkg::bge:  return $signed(a) >= $signed(b);
        rv_exe_pkg::bltu: return a < b;
        default:          return a >= b;
    endcase
endfunction

function automatic rv_exe_pkg::word_t ref_operand(rv_exe_pkg::fwd_sel_t sel,
        rv_exe_pkg::word_t rf, rv_exe_pkg::word_t ex, rv_exe_pkg::word_t mem,
        rv_exe_pkg::word_t wb);
    case (sel)
        rv_exe_pkg::fwd_regfile: return rf;
        rv_exe_pkg::fwd_exe:     return ex;
        rv_exe_pkg::fwd_mem:     return mem;
        default:                 return wb;
    endcase
endfunction

function automatic rv_exe_pkg::word_t ref_next_pc(rv_exe_pkg::opcode_t op, logic taken,
        rv_exe_pkg::word_t alu_out, rv_exe_pkg::word_t pc_dec);
    if (op == rv_exe_pkg::op_jal || (op == rv_exe_pkg::op_br && taken)) return alu_out;
    if (op == rv_exe_pkg::op_jalr) return alu_out & 32'hffff_fffe;
    return pc_dec;
endfunction

// expected execute-to-memory packet for one decode packet
function automatic rv_exe_pkg::ex_mem_t ref_execute(logic valid, rv_exe_pkg::de_exe_t p,
        rv_exe_pkg::word_t ex, rv_exe_pkg::word_t mem, rv_exe_pkg::word_t wb);
    rv_exe_pkg::ex_mem_t r;
    rv_exe_pkg::word_t   rs1;
    rv_exe_pkg::word_t   rs2;
    rv_exe_pkg::word_t   a;
    rv_exe_pkg::word_t   b;
    if (!valid) return rv_exe_pkg::bubble_ex_mem;
    rs1 = ref_operand(p.ctrl.exe.rs1_sel, p.ctrl.rvfi.rs1_data, ex, mem, wb);
    rs2 = ref_operand(p.ctrl.exe.rs2_sel, p.ctrl.rvfi.rs2_data, ex, mem, wb);
    a = (p.ctrl.exe.alu1_sel == rv_exe_pkg::alu1_pc) ? p.ctrl.rvfi.pc_rdata : rs1;
    case (p.ctrl.exe.alu2_sel)
        rv_exe_pkg::alu2_i_imm: b = p.imm.i_imm;
        rv_exe_pkg::alu2_u_imm: b = p.imm.u_imm;
        rv_exe_pkg::alu2_b_imm: b = p.imm.b_imm;
        rv_exe_pkg::alu2_s_imm: b = p.imm.s_imm;
        rv_exe_pkg::alu2_j_imm: b = p.imm.j_imm;
        default:                b = rs2;
    endcase
    r.ctrl = p.ctrl;
    r.ctrl.rvfi.rs1_data = rs1;
    r.ctrl.rvfi.rs2_data = rs2;
    r.alu_out = ref_alu(p.ctrl.exe.aluop, a, b);
    r.br_en = ref_cmp(p.ctrl.exe.cmpop, rs1,
                      (p.ctrl.exe.cmp_sel == rv_exe_pkg::cmp_i_imm) ? p.imm.i_imm : rs2);
    r.ctrl.rvfi.pc_wdata = ref_next_pc(p.opcode, r.br_en, r.alu_out, p.ctrl.rvfi.pc_wdata);
    return r;
endfunction

`endif

// ==== bench/exe_tb.sv ====
`timescale 1ns/1ps

module exe_tb;

    `include "exe_ref_model.svh"

    localparam int NUM_PKTS = 91; // packets issued by the sequence, drain included

    logic                clk;
    logic                arst_n_i;
    logic                in_valid_i;
    rv_exe_pkg::de_exe_t in_pkt_i;
    logic                stall_i;
    rv_exe_pkg::word_t   mem_fwd_data_i;
    rv_exe_pkg::word_t   wb_fwd_data_i;
    logic                out_valid_o;
    rv_exe_pkg::ex_mem_t out_pkt_o;

    logic                exp_valid; // scoreboard view of the output register
    rv_exe_pkg::ex_mem_t exp_pkt;
    logic                pend_valid[$];
    rv_exe_pkg::de_exe_t pend_pkt[$];
    int                  stall_total;
    logic [63:0]         order_cnt;

    exe_top dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .in_valid_i     (in_valid_i),
        .in_pkt_i       (in_pkt_i),
        .stall_i        (stall_i),
        .mem_fwd_data_i (mem_fwd_data_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .out_valid_o    (out_valid_o),
        .out_pkt_o      (out_pkt_o)
    );

    always #50 clk = ~clk;

    // packet in u_de_exe moves out on each edge without stall
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_valid.delete();
            pend_pkt.delete();
            pend_valid.push_back(1'b0);
            pend_pkt.push_back('0);
            exp_valid <= 1'b0;
            exp_pkt   <= rv_exe_pkg::bubble_ex_mem;
        end else if (!stall_i) begin
            exp_valid <= pend_valid[0];
            exp_pkt   <= ref_execute(pend_valid[0], pend_pkt[0], exp_pkt.alu_out,
                                     mem_fwd_data_i, wb_fwd_data_i);
            void'(pend_valid.pop_front());
            void'(pend_pkt.pop_front());
            pend_valid.push_back(in_valid_i);
            pend_pkt.push_back(in_pkt_i);
        end
    end

    a_out_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_valid_o == exp_valid && out_pkt_o == exp_pkt)
    else begin
        $display("FAILED %0t: out packet %h differs from model %h", $time, out_pkt_o, exp_pkt);
        $display("Done: errors found");
        $fatal(1);
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable(out_pkt_o) && $stable(out_valid_o))
    else begin
        $display("FAILED %0t: output changed during a stall", $time);
        $display("Done: errors found");
        $fatal(1);
    end

    function automatic rv_exe_pkg::de_exe_t make_pkt(rv_exe_pkg::opcode_t op,
            rv_exe_pkg::alu_op_t aluop, rv_exe_pkg::cmp_op_t cmpop,
            rv_exe_pkg::alu1_sel_t a1, rv_exe_pkg::alu2_sel_t a2,
            rv_exe_pkg::fwd_sel_t s1, rv_exe_pkg::fwd_sel_t s2, logic [63:0] order);
        rv_exe_pkg::de_exe_t p;
        p = '0;
        p.opcode             = op;
        p.ctrl.exe.aluop     = aluop;
        p.ctrl.exe.cmpop     = cmpop;
        p.ctrl.exe.alu1_sel  = a1;
        p.ctrl.exe.alu2_sel  = a2;
        p.ctrl.exe.rs1_sel   = s1;
        p.ctrl.exe.rs2_sel   = s2;
        p.ctrl.exe.cmp_sel   = $urandom_range(1) ? rv_exe_pkg::cmp_i_imm : rv_exe_pkg::cmp_rs2;
        p.ctrl.mem.mem_write = (op == rv_exe_pkg::op_store);
        p.ctrl.mem.funct3    = 3'($urandom);
        p.ctrl.wb.ld_reg     = 1'($urandom);
        p.ctrl.wb.rd_addr    = 5'($urandom);
        p.ctrl.rvfi.valid    = 1'b1;
        p.ctrl.rvfi.order    = order;
        p.ctrl.rvfi.insn     = $urandom;
        p.ctrl.rvfi.rs1_addr = 5'($urandom);
        p.ctrl.rvfi.rs2_addr = 5'($urandom);
        p.ctrl.rvfi.rs1_data = $urandom;
        p.ctrl.rvfi.rs2_data = ($urandom_range(3) == 0) ? p.ctrl.rvfi.rs1_data : $urandom;
        p.ctrl.rvfi.pc_rdata = $urandom & 32'hffff_fffc;
        p.ctrl.rvfi.pc_wdata = p.ctrl.rvfi.pc_rdata + 32'd4; // sequential fall-through
        p.imm.i_imm          = $urandom;
        p.imm.s_imm          = $urandom;
        p.imm.b_imm          = $urandom & 32'hffff_fffe;
        p.imm.u_imm          = $urandom & 32'hffff_f000;
        p.imm.j_imm          = $urandom & 32'hffff_fffe;
        return p;
    endfunction

    task automatic issue(input logic valid, input rv_exe_pkg::de_exe_t p);
        @(posedge clk);
        #10;
        stall_i        = 1'b0;
        in_valid_i     = valid;
        in_pkt_i       = p;
        mem_fwd_data_i = $urandom;
        wb_fwd_data_i  = $urandom;
        order_cnt      = order_cnt + 64'd1;
    endtask

    // inputs stay put while the pipeline holds
    task automatic hold_pipeline(input int cycles);
        @(posedge clk);
        #10;
        stall_i = 1'b1;
        stall_total += cycles;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic random_fwd_sels(output rv_exe_pkg::fwd_sel_t s1,
                                   output rv_exe_pkg::fwd_sel_t s2);
        s1 = rv_exe_pkg::fwd_sel_t'($urandom_range(3));
        s2 = rv_exe_pkg::fwd_sel_t'($urandom_range(3));
    endtask

    initial begin
        rv_exe_pkg::cmp_op_t  cmp_list[6];
        rv_exe_pkg::fwd_sel_t s1;
        rv_exe_pkg::fwd_sel_t s2;
        void'($urandom(45615));
        cmp_list = '{rv_exe_pkg::beq, rv_exe_pkg::bne, rv_exe_pkg::blt,
                     rv_exe_pkg::bge, rv_exe_pkg::bltu, rv_exe_pkg::bgeu};
        clk = 1'b0;
        arst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_pkt_i = '0;
        stall_i = 1'b0;
        mem_fwd_data_i = '0;
        wb_fwd_data_i = '0;
        stall_total = 0;
        order_cnt = '0;
        repeat (3) @(posedge clk);
        #10;
        arst_n_i = 1'b1;
        repeat (2) @(posedge clk); // bubble word held after reset

        for (int i = 0; i < 30; i++) begin // register alu ops, random forwarding
            random_fwd_sels(s1, s2);
            issue(1'b1, make_pkt(rv_exe_pkg::op_reg, rv_exe_pkg::alu_op_t'(i % 10),
                  rv_exe_pkg::beq, rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_rs2, s1, s2, order_cnt));
            if ($urandom_range(4) == 0) hold_pipeline($urandom_range(1, 3));
        end
        for (int i = 0; i < 4; i++) begin // operand selection
            issue(1'b1, make_pkt(rv_exe_pkg::op_auipc, rv_exe_pkg::alu_add, rv_exe_pkg::beq,
                  rv_exe_pkg::alu1_pc, rv_exe_pkg::alu2_u_imm, rv_exe_pkg::fwd_regfile,
                  rv_exe_pkg::fwd_regfile, order_cnt));
            issue(1'b1, make_pkt(rv_exe_pkg::op_lui, rv_exe_pkg::alu_or, rv_exe_pkg::beq,
                  rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_u_imm, rv_exe_pkg::fwd_regfile,
                  rv_exe_pkg::fwd_regfile, order_cnt));
            issue(1'b1, make_pkt(rv_exe_pkg::op_store, rv_exe_pkg::alu_add, rv_exe_pkg::beq,
                  rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_s_imm, rv_exe_pkg::fwd_exe,
                  rv_exe_pkg::fwd_mem, order_cnt));
            issue(1'b1, make_pkt(rv_exe_pkg::op_imm, rv_exe_pkg::alu_op_t'($urandom_range(9)),
                  rv_exe_pkg::beq, rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_i_imm,
                  rv_exe_pkg::fwd_wb, rv_exe_pkg::fwd_exe, order_cnt));
        end
        for (int i = 0; i < 24; i++) begin // branches on all six relations
            random_fwd_sels(s1, s2);
            issue(1'b1, make_pkt(rv_exe_pkg::op_br, rv_exe_pkg::alu_add, cmp_list[i % 6],
                  rv_exe_pkg::alu1_pc, rv_exe_pkg::alu2_b_imm, s1, s2, order_cnt));
            if ($urandom_range(4) == 0) hold_pipeline($urandom_range(1, 3));
        end
        for (int i = 0; i < 6; i++) begin // jumps, then bubbles
            random_fwd_sels(s1, s2);
            issue(1'b1, make_pkt(rv_exe_pkg::op_jal, rv_exe_pkg::alu_add, rv_exe_pkg::beq,
                  rv_exe_pkg::alu1_pc, rv_exe_pkg::alu2_j_imm, s1, s2, order_cnt));
            issue(1'b1, make_pkt(rv_exe_pkg::op_jalr, rv_exe_pkg::alu_add, rv_exe_pkg::bne,
                  rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_i_imm, s1, s2, order_cnt));
            issue(1'b0, make_pkt(rv_exe_pkg::op_reg, rv_exe_pkg::alu_sub, rv_exe_pkg::blt,
                  rv_exe_pkg::alu1_rs1, rv_exe_pkg::alu2_rs2, s1, s2, order_cnt));
        end
        repeat (3) issue(1'b0, '0); // drain
        repeat (2) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

    // limit grows with every stall the sequence inserts
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < NUM_PKTS + stall_total + 20) begin
            #100;
            cycles++;
        end
        $display("timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

// ==== exe_sub.f ====
+incdir+include
hdl/rv_exe_pkg.sv
hdl/alu.sv
hdl/branch_cmp.sv
hdl/pipe_reg.sv
hdl/exe_stage.sv
hdl/exe_top.sv
bench/exe_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_exe_pkg::alu_op_t aluop_i,
    input  rv_exe_pkg::word_t   a_i,
    input  rv_exe_pkg::word_t   b_i,
    output rv_exe_pkg::word_t   f_o
);

    logic [4:0] shamt; // rv32i shifts use five bits

    assign shamt = b_i[4:0];

    always_comb begin
        case (aluop_i)
            rv_exe_pkg::alu_add:  f_o = a_i + b_i;
            rv_exe_pkg::alu_sub:  f_o = a_i - b_i;
            rv_exe_pkg::alu_sll:  f_o = a_i << shamt;
            rv_exe_pkg::alu_slt: begin
                f_o = {31'd0, $signed(a_i) < $signed(b_i)};
            end
            rv_exe_pkg::alu_sltu: begin
                f_o = {31'd0, a_i < b_i};
            end
            rv_exe_pkg::alu_xor:  f_o = a_i ^ b_i;
            rv_exe_pkg::alu_srl:  f_o = a_i >> shamt;
            rv_exe_pkg::alu_sra: begin
                f_o = rv_exe_pkg::word_t'($signed(a_i) >>> shamt); // sign fill
            end
            rv_exe_pkg::alu_or:   f_o = a_i | b_i;
            rv_exe_pkg::alu_and:  f_o = a_i & b_i;
            default:              f_o = '0; // encodings 10 to 15 unused
        endcase
    end

endmodule

// ==== hdl/branch_cmp.sv ====
`timescale 1ns/1ps

module branch_cmp (
    input  rv_exe_pkg::cmp_op_t cmpop_i,
    input  rv_exe_pkg::word_t   a_i,
    input  rv_exe_pkg::word_t   b_i,
    output logic                br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            rv_exe_pkg::beq:  br_en_o = eq;
            rv_exe_pkg::bne:  br_en_o = !eq;
            rv_exe_pkg::blt:  br_en_o = lt_s;
            rv_exe_pkg::bge:  br_en_o = !lt_s;
            rv_exe_pkg::bltu: br_en_o = lt_u;
            rv_exe_pkg::bgeu: br_en_o = !lt_u;
            default:          br_en_o = 1'b0; // funct3 010 and 011 are not branches
        endcase
    end

    // decode never hands over the two reserved funct3 codes
    always_comb begin
        if (!$isunknown(cmpop_i)) begin
            assert (cmpop_i inside {rv_exe_pkg::beq, rv_exe_pkg::bne, rv_exe_pkg::blt,
                                    rv_exe_pkg::bge, rv_exe_pkg::bltu, rv_exe_pkg::bgeu})
                else $error("illegal compare op %b", cmpop_i);
        end
    end

endmodule

// ==== hdl/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                clk,
    input  logic                de_valid_i,
    input  rv_exe_pkg::de_exe_t de_pkt_i,
    input  rv_exe_pkg::word_t   exe_fwd_data_i,
    input  rv_exe_pkg::word_t   mem_fwd_data_i,
    input  rv_exe_pkg::word_t   wb_fwd_data_i,
    output rv_exe_pkg::ex_mem_t ex_pkt_o
);

    rv_exe_pkg::exe_ctrl_t exe_ctrl;
    rv_exe_pkg::imm_t      imm;
    rv_exe_pkg::opcode_t   opcode;

    rv_exe_pkg::word_t rs1_val; // after forwarding
    rv_exe_pkg::word_t rs2_val;
    rv_exe_pkg::word_t cmp_b;
    rv_exe_pkg::word_t alu_a;
    rv_exe_pkg::word_t alu_b;
    rv_exe_pkg::word_t alu_out;
    rv_exe_pkg::word_t pc_next;
    logic              br_en;

    assign exe_ctrl = de_pkt_i.ctrl.exe;
    assign imm      = de_pkt_i.imm;
    assign opcode   = de_pkt_i.opcode;

    // forwarding muxes
    always_comb begin
        case (exe_ctrl.rs1_sel)
            rv_exe_pkg::fwd_regfile: rs1_val = de_pkt_i.ctrl.rvfi.rs1_data;
            rv_exe_pkg::fwd_exe:     rs1_val = exe_fwd_data_i;
            rv_exe_pkg::fwd_mem:     rs1_val = mem_fwd_data_i;
            default:                 rs1_val = wb_fwd_data_i;
        endcase

        case (exe_ctrl.rs2_sel)
            rv_exe_pkg::fwd_regfile: rs2_val = de_pkt_i.ctrl.rvfi.rs2_data;
            rv_exe_pkg::fwd_exe:     rs2_val = exe_fwd_data_i;
            rv_exe_pkg::fwd_mem:     rs2_val = mem_fwd_data_i;
            default:                 rs2_val = wb_fwd_data_i;
        endcase
    end

    // operand muxes
    always_comb begin
        case (exe_ctrl.cmp_sel)
            rv_exe_pkg::cmp_i_imm: cmp_b = imm.i_imm;
            default:               cmp_b = rs2_val;
        endcase

        case (exe_ctrl.alu1_sel)
            rv_exe_pkg::alu1_pc: alu_a = de_pkt_i.ctrl.rvfi.pc_rdata;
            default:             alu_a = rs1_val;
        endcase

        case (exe_ctrl.alu2_sel)
            rv_exe_pkg::alu2_i_imm: alu_b = imm.i_imm;
            rv_exe_pkg::alu2_u_imm: alu_b = imm.u_imm;
            rv_exe_pkg::alu2_b_imm: alu_b = imm.b_imm; // branch target pc + b_imm
            rv_exe_pkg::alu2_s_imm: alu_b = imm.s_imm;
            rv_exe_pkg::alu2_j_imm: alu_b = imm.j_imm;
            default:                alu_b = rs2_val;
        endcase
    end

    alu u_alu (
        .aluop_i (exe_ctrl.aluop),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .f_o     (alu_out)
    );

    branch_cmp u_cmp (
        .cmpop_i (exe_ctrl.cmpop),
        .a_i     (rs1_val),
        .b_i     (cmp_b),
        .br_en_o (br_en)
    );

    // next pc rewrite for control flow
    always_comb begin
        pc_next = de_pkt_i.ctrl.rvfi.pc_wdata; // fall-through from decode
        if ((br_en && opcode == rv_exe_pkg::op_br) || opcode == rv_exe_pkg::op_jal) begin
            pc_next = alu_out;
        end else if (opcode == rv_exe_pkg::op_jalr) begin
            pc_next = {alu_out[31:1], 1'b0}; // jalr clears bit 0
        end
    end

    // packet build and bubble insertion
    always_comb begin
        if (!de_valid_i) begin
            ex_pkt_o = rv_exe_pkg::bubble_ex_mem;
        end else begin
            ex_pkt_o.ctrl               = de_pkt_i.ctrl;
            ex_pkt_o.ctrl.rvfi.rs1_data = rs1_val;
            ex_pkt_o.ctrl.rvfi.rs2_data = rs2_val;
            ex_pkt_o.ctrl.rvfi.pc_wdata = pc_next;
            ex_pkt_o.alu_out            = alu_out;
            ex_pkt_o.br_en              = br_en;
        end
    end

    // decode must supply known alu selects with every valid packet
    a_alu_sel_known: assert property (
        @(posedge clk)
        de_valid_i |-> !$isunknown({exe_ctrl.alu1_sel, exe_ctrl.alu2_sel})
    ) else $error("unknown alu select on a valid packet");

endmodule

// ==== hdl/exe_top.sv ====
`timescale 1ns/1ps

module exe_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  rv_exe_pkg::de_exe_t in_pkt_i,
    input  logic                stall_i,
    input  rv_exe_pkg::word_t   mem_fwd_data_i,
    input  rv_exe_pkg::word_t   wb_fwd_data_i,
    output logic                out_valid_o,
    output rv_exe_pkg::ex_mem_t out_pkt_o
);

    logic                de_valid;
    rv_exe_pkg::de_exe_t de_pkt;
    rv_exe_pkg::ex_mem_t ex_pkt;
    rv_exe_pkg::word_t   exe_fwd_data;

    // result of the instruction one ahead, taken from the output register
    assign exe_fwd_data = out_pkt_o.alu_out;

    pipe_reg #(
        .payload_t (rv_exe_pkg::de_exe_t)
    ) u_de_exe (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .valid_i  (in_valid_i),
        .data_i   (in_pkt_i),
        .valid_o  (de_valid),
        .data_o   (de_pkt)
    );

    exe_stage u_exe (
        .clk            (clk),
        .de_valid_i     (de_valid),
        .de_pkt_i       (de_pkt),
        .exe_fwd_data_i (exe_fwd_data),
        .mem_fwd_data_i (mem_fwd_data_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .ex_pkt_o       (ex_pkt)
    );

    pipe_reg #(
        .payload_t (rv_exe_pkg::ex_mem_t),
        .RESET_VAL (rv_exe_pkg::bubble_ex_mem) // memory stage sees a bubble out of reset
    ) u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .valid_i  (de_valid),
        .data_i   (ex_pkt),
        .valid_o  (out_valid_o),
        .data_o   (out_pkt_o)
    );

endmodule

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= RESET_VAL;
        end else if (!stall_i) begin
            valid_o <= valid_i; // advance one stage
            data_o  <= data_i;
        end
    end

    // the strobe must stay clean for the next stage once reset is gone
    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(valid_o)
    ) else $error("pipe_reg valid_o is unknown");

endmodule

// ==== hdl/rv_exe_pkg.sv ====
package rv_exe_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111, // load upper immediate
        op_auipc = 7'b0010111, // add upper immediate to pc
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011, // conditional branches
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011, // register-immediate alu ops
        op_reg   = 7'b0110011  // register-register alu ops
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // comparator ops carry the funct3 of the branch
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {
        fwd_regfile = 2'b00, // value read in decode
        fwd_exe     = 2'b01, // result of the instruction one ahead
        fwd_mem     = 2'b10,
        fwd_wb      = 2'b11
    } fwd_sel_t;

    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alu1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm = 3'd0,
        alu2_u_imm = 3'd1,
        alu2_b_imm = 3'd2,
        alu2_s_imm = 3'd3,
        alu2_j_imm = 3'd4,
        alu2_rs2   = 3'd5
    } alu2_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1 // slti and sltiu style compares
    } cmp_sel_t;

    typedef struct packed {
        word_t i_imm;
        word_t s_imm;
        word_t b_imm;
        word_t u_imm;
        word_t j_imm;
    } imm_t;

    typedef struct packed {
        fwd_sel_t  rs1_sel;
        fwd_sel_t  rs2_sel;
        alu1_sel_t alu1_sel;
        alu2_sel_t alu2_sel;
        cmp_sel_t  cmp_sel;
        alu_op_t   aluop;
        cmp_op_t   cmpop;
    } exe_ctrl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3; // access width and sign
    } mem_ctrl_t;

    typedef struct packed {
        logic       ld_reg;
        logic [4:0] rd_addr;
    } wb_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] order;
        word_t       insn;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        word_t       rs1_data;
        word_t       rs2_data;
        word_t       pc_rdata;
        word_t       pc_wdata; // next pc, rewritten in execute
    } rvfi_t;

    typedef struct packed {
        exe_ctrl_t exe;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        rvfi_t     rvfi;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        opcode_t    opcode;
        imm_t       imm;
    } de_exe_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      alu_out;
        logic       br_en;
    } ex_mem_t;

    localparam word_t BUBBLE_PC = 32'h4000_0000;

    localparam ctrl_word_t bubble_ctrl = '{
        exe: '{
            rs1_sel:  fwd_regfile,
            rs2_sel:  fwd_regfile,
            alu1_sel: alu1_rs1,
            alu2_sel: alu2_i_imm,
            cmp_sel:  cmp_rs2,
            aluop:    alu_add,
            cmpop:    beq
        },
        mem: '{mem_read: 1'b0, mem_write: 1'b0, funct3: 3'b000},
        wb: '{ld_reg: 1'b0, rd_addr: 5'd0},
        rvfi: '{
            valid:    1'b0,
            order:    64'd0,
            insn:     32'd0,
            rs1_addr: 5'd0,
            rs2_addr: 5'd0,
            rs1_data: 32'd0,
            rs2_data: 32'd0,
            pc_rdata: BUBBLE_PC,
            pc_wdata: 32'd0
        }
    };

    // full execute-to-memory bubble
    localparam ex_mem_t bubble_ex_mem = '{
        ctrl:    bubble_ctrl,
        alu_out: 32'd0,
        br_en:   1'b0
    };

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the execute-stage testbench with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exe_sub.f --top-module exe_tb -o vexe_tb \
    && ./obj_dir/vexe_tb > sim.log 2>&1 \
    || { echo "build or simulation failed"; }

grep -q "Done: no errors" sim.log 2>/dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
